//--- design/video_pkg.sv
package video_pkg;

	// ======================================================================
	// Frame geometry
	// ======================================================================

	// Default VGA frame size
	localparam int FRAME_W_DEFAULT = 640;
	localparam int FRAME_H_DEFAULT = 480;

	// Pixel address, enough for 640 x 480
	localparam int ADDR_W = 19;

	// Solver number width
	localparam int SOLVER_W = 6;

	// ======================================================================
	// Pixel colours
	// ======================================================================

	// Odd solvers
	localparam logic [7:0] COLOR_ODD = 8'h1F;
	// Even solvers
	localparam logic [7:0] COLOR_EVEN = 8'h03;

	// ======================================================================
	// Stream beat and frame counter
	// ======================================================================

	// One beat of the pixel stream, 29 bits
	typedef struct packed {
		// Start of packet, first pixel of a frame
		logic              sop;
		// End of packet, last pixel of a frame
		logic              eop;
		// Linear pixel address
		logic [ADDR_W-1:0] addr;
		// Colour byte
		logic [7:0]        color;
	} pixel_beat_t;

	// Completed frames, four hex digits
	localparam int FRAME_COUNT_W = 16;

endpackage

//--- design/pixel_scan.sv
`timescale 1ns/1ns

module pixel_scan import video_pkg::*; #(
	parameter int FRAME_W     = FRAME_W_DEFAULT,
	parameter int FRAME_H     = FRAME_H_DEFAULT,
	parameter int NUM_SOLVERS = 2
) (
	input  logic        iCLK,
	input  logic        rst,
	input  logic        full,
	output logic        wr_en,
	output pixel_beat_t wr_beat
);

	// Counter widths
	localparam int X_W = (FRAME_W > 1) ? $clog2(FRAME_W) : 1;
	localparam int Y_W = (FRAME_H > 1) ? $clog2(FRAME_H) : 1;

	// Scan position
	logic [X_W-1:0]      x;
	logic [Y_W-1:0]      y;
	logic [ADDR_W-1:0]   addr;
	logic [SOLVER_W-1:0] solver;

	// Goes high one cycle after reset release
	logic active;

	logic last_x;
	logic last_y;

	assign last_x = (x == X_W'(FRAME_W - 1));
	assign last_y = (y == Y_W'(FRAME_H - 1));

	// Write whenever the buffer has room
	assign wr_en = active & ~full;

	// Beat for the current scan position
	always_comb begin
		wr_beat.sop   = (x == '0) && (y == '0);
		wr_beat.eop   = last_x && last_y;
		wr_beat.addr  = addr;
		// Low bit of solver picks the colour
		wr_beat.color = solver[0] ? COLOR_ODD : COLOR_EVEN;
	end

	// ======================================================================
	// Raster walk
	// ======================================================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			active <= 1'b0;
			x      <= '0;
			y      <= '0;
			addr   <= '0;
			solver <= '0;
		end else begin
			active <= 1'b1;
			// Position holds while full
			if (wr_en) begin
				if (last_x) begin
					x <= '0;
					if (last_y) begin
						// Frame wraps to pixel 0
						y    <= '0;
						addr <= '0;
					end else begin
						y    <= y + 1'b1;
						addr <= addr + 1'b1;
					end
				end else begin
					x    <= x + 1'b1;
					addr <= addr + 1'b1;
				end
				// Round-robin solver, continues across frames
				if (solver == SOLVER_W'(NUM_SOLVERS - 1))
					solver <= '0;
				else
					solver <= solver + 1'b1;
			end
		end
	end

endmodule

//--- design/pixel_fifo.sv
`timescale 1ns/1ns

module pixel_fifo import video_pkg::*; #(
	parameter int FIFO_DEPTH = 256
) (
	input  logic        iCLK,
	input  logic        rst,
	input  logic        wr_en,
	input  pixel_beat_t wr_beat,
	output logic        full,
	input  logic        rd_en,
	output logic        empty,
	output pixel_beat_t rd_beat
);

	// Pointer and occupancy widths
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = PTR_W + 1;

	// Beat storage, block RAM style
	pixel_beat_t mem [FIFO_DEPTH-1:0];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr_en & ~full;
	assign rd_ok = rd_en & ~empty;

	// Write port
	always_ff @(posedge iCLK) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_beat;
	end

	// Oldest entry falls through
	assign rd_beat = mem[rd_ptr];

	// Read and write together leave the count alone
	always_comb begin
		case ({wr_ok, rd_ok})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	// ======================================================================
	// Pointers and flags
	// ======================================================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			// Pointers wrap at the power-of-two depth
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			// Flags from next occupancy
			full  <= (count_next == CNT_W'(FIFO_DEPTH));
			empty <= (count_next == '0);
		end
	end

endmodule

//--- design/video_stream_out.sv
`timescale 1ns/1ns

module video_stream_out import video_pkg::*; (
	input  logic                     iCLK,
	input  logic                     rst,
	input  logic                     empty,
	input  pixel_beat_t              rd_beat,
	output logic                     rd_en,
	input  logic                     ready,
	output logic                     valid,
	output logic                     sop,
	output logic                     eop,
	output logic [7:0]               data,
	output logic [ADDR_W-1:0]        addr,
	output logic [FRAME_COUNT_W-1:0] frame_count
);

	// Beat handed to the sink this cycle
	logic accept;
	// Output slot free or draining
	logic slot_free;
	// Refill from the buffer
	logic load;

	assign accept    = valid & ready;
	assign slot_free = ~valid | ready;
	assign load      = slot_free & ~empty;

	// Pop in the same cycle the slot loads
	assign rd_en = load;

	// ======================================================================
	// Output register, control part
	// ======================================================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			valid <= 1'b0;
			sop   <= 1'b0;
			eop   <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
			sop   <= rd_beat.sop;
			eop   <= rd_beat.eop;
		end else if (accept) begin
			// Slot drained, nothing behind it
			valid <= 1'b0;
			sop   <= 1'b0;
			eop   <= 1'b0;
		end
	end

	// Payload, holds under back-pressure
	always_ff @(posedge iCLK) begin
		if (load) begin
			data <= rd_beat.color;
			addr <= rd_beat.addr;
		end
	end

	// ======================================================================
	// Completed frames
	// ======================================================================
	always_ff @(posedge iCLK) begin
		if (rst)
			frame_count <= '0;
		else if (accept && eop)
			frame_count <= frame_count + 1'b1;
	end

endmodule

//--- design/hex_display.sv
`timescale 1ns/1ns

module hex_display import video_pkg::*; (
	input  logic [FRAME_COUNT_W-1:0] frame_count,
	output logic [6:0]               hex0,
	output logic [6:0]               hex1,
	output logic [6:0]               hex2,
	output logic [6:0]               hex3
);

	// Hex font, segment a in bit 0, active low
	function automatic logic [6:0] seg_decode(input logic [3:0] nibble);
		logic [6:0] on;
		case (nibble)
			4'h0: on = 7'h3F;
			4'h1: on = 7'h06;
			4'h2: on = 7'h5B;
			4'h3: on = 7'h4F;
			4'h4: on = 7'h66;
			4'h5: on = 7'h6D;
			4'h6: on = 7'h7D;
			4'h7: on = 7'h07;
			4'h8: on = 7'h7F;
			4'h9: on = 7'h6F;
			4'hA: on = 7'h77;
			4'hB: on = 7'h7C;
			4'hC: on = 7'h39;
			4'hD: on = 7'h5E;
			4'hE: on = 7'h79;
			default: on = 7'h71;
		endcase
		// Segments light on a low level
		return ~on;
	endfunction

	// Lowest nibble on hex0
	always_comb begin
		hex0 = seg_decode(frame_count[3:0]);
		hex1 = seg_decode(frame_count[7:4]);
		hex2 = seg_decode(frame_count[11:8]);
		hex3 = seg_decode(frame_count[15:12]);
	end

endmodule

//--- design/video_stream_top.sv
`timescale 1ns/1ns

module video_stream_top import video_pkg::*; #(
	parameter int FRAME_W     = FRAME_W_DEFAULT,
	parameter int FRAME_H     = FRAME_H_DEFAULT,
	parameter int NUM_SOLVERS = 2,
	parameter int FIFO_DEPTH  = 256
) (
	input  logic              iCLK,
	input  logic              rst,
	// Video sink
	input  logic              ready,
	output logic              valid,
	output logic              sop,
	output logic              eop,
	output logic [7:0]        data,
	output logic [ADDR_W-1:0] addr,
	// Frame counter digits, active low
	output logic [6:0]        hex0,
	output logic [6:0]        hex1,
	output logic [6:0]        hex2,
	output logic [6:0]        hex3
);

	// Producer side of the buffer
	logic        wr_en;
	pixel_beat_t wr_beat;
	logic        full;

	// Consumer side of the buffer
	logic        rd_en;
	logic        empty;
	pixel_beat_t rd_beat;

	logic [FRAME_COUNT_W-1:0] frame_count;

	// ======================================================================
	// Pixel path
	// ======================================================================
	pixel_scan #(
		.FRAME_W     (FRAME_W),
		.FRAME_H     (FRAME_H),
		.NUM_SOLVERS (NUM_SOLVERS)
	) i_pixel_scan (
		.iCLK    (iCLK),
		.rst     (rst),
		.full    (full),
		.wr_en   (wr_en),
		.wr_beat (wr_beat)
	);

	pixel_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_pixel_fifo (
		.iCLK    (iCLK),
		.rst     (rst),
		.wr_en   (wr_en),
		.wr_beat (wr_beat),
		.full    (full),
		.rd_en   (rd_en),
		.empty   (empty),
		.rd_beat (rd_beat)
	);

	video_stream_out i_video_stream_out (
		.iCLK        (iCLK),
		.rst         (rst),
		.empty       (empty),
		.rd_beat     (rd_beat),
		.rd_en       (rd_en),
		.ready       (ready),
		.valid       (valid),
		.sop         (sop),
		.eop         (eop),
		.data        (data),
		.addr        (addr),
		.frame_count (frame_count)
	);

	// Frame count on four digits
	hex_display i_hex_display (
		.frame_count (frame_count),
		.hex0        (hex0),
		.hex1        (hex1),
		.hex2        (hex2),
		.hex3        (hex3)
	);

endmodule

//--- tests/stream_checker.sv
`timescale 1ns/1ns

module stream_checker import video_pkg::*; (
	input logic              iCLK,
	input logic              rst,
	input logic              ready,
	input logic              valid,
	input logic              sop,
	input logic              eop,
	input logic [7:0]        data,
	input logic [ADDR_W-1:0] addr
);

	// Count of failed assertions for the closing report
	int assert_errors = 0;

	// Output register clears under reset
	valid_in_reset: assert property (@(posedge iCLK) rst |=> !valid)
		else begin
			assert_errors++;
			$error("valid high while reset is applied");
		end

	// Stalled beat keeps valid
	valid_held: assert property (@(posedge iCLK) disable iff (rst)
		valid && !ready |=> valid)
		else begin
			assert_errors++;
			$error("valid dropped before the beat was taken");
		end

	// Stalled beat keeps its payload
	payload_held: assert property (@(posedge iCLK) disable iff (rst)
		valid && !ready |=> $stable({data, addr, sop, eop}))
		else begin
			assert_errors++;
			$error("stream payload changed under back-pressure");
		end

	// Packet marks only ride on a valid beat
	marks_need_valid: assert property (@(posedge iCLK) disable iff (rst)
		!valid |-> !sop && !eop)
		else begin
			assert_errors++;
			$error("sop or eop high without valid");
		end

endmodule

//--- tests/stream_monitor.sv
`timescale 1ns/1ns

module stream_monitor import video_pkg::*; #(
	parameter int FRAME_W     = 8,
	parameter int FRAME_H     = 4,
	parameter int NUM_SOLVERS = 3
) (
	input  logic              iCLK,
	input  logic              rst,
	input  logic              ready,
	input  logic              valid,
	input  logic              sop,
	input  logic              eop,
	input  logic [7:0]        data,
	input  logic [ADDR_W-1:0] addr,
	input  logic [6:0]        hex0,
	input  logic [6:0]        hex1,
	input  logic [6:0]        hex2,
	input  logic [6:0]        hex3,
	output int                frames_done,
	output int                beat_errors,
	output int                hold_errors,
	output int                hex_errors
);

	localparam int LAST_PIX = FRAME_W * FRAME_H - 1;

	// Predicted stream position
	int pix_idx;
	int solver_idx;
	int beats_seen;
	logic first_cycle;

	// Values seen under back-pressure
	logic              hold_pending;
	logic              held_sop;
	logic              held_eop;
	logic [7:0]        held_data;
	logic [ADDR_W-1:0] held_addr;

	// Active-low digit patterns, segment a in bit 0
	function automatic logic [6:0] segments_for(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// Digits show frames already counted
	task automatic check_digits();
		logic [15:0] want;
		want = 16'(frames_done);
		if (hex0 !== segments_for(want[3:0]) || hex1 !== segments_for(want[7:4]) ||
			hex2 !== segments_for(want[11:8]) || hex3 !== segments_for(want[15:12])) begin
			$display("error at %0t: digits %h %h %h %h do not show frame count %h",
				$time, hex3, hex2, hex1, hex0, want);
			hex_errors++;
		end
	endtask

	// Output must not move while stalled
	task automatic verify_hold();
		if (valid !== 1'b1 || sop !== held_sop || eop !== held_eop ||
			data !== held_data || addr !== held_addr) begin
			$display("error at %0t: stalled beat changed, addr %0d now %0d valid %b",
				$time, held_addr, addr, valid);
			hold_errors++;
		end
	endtask

	// One accepted beat against the predicted raster position
	task automatic compare_beat();
		logic [7:0] want_color;
		// Colour from the solver number of this beat
		want_color = (solver_idx % 2 == 1) ? COLOR_ODD : COLOR_EVEN;
		if (addr !== ADDR_W'(pix_idx)) begin
			$display("error at %0t: beat %0d addr %0d, expected %0d",
				$time, beats_seen, addr, pix_idx);
			beat_errors++;
		end
		if (sop !== (pix_idx == 0) || eop !== (pix_idx == LAST_PIX)) begin
			$display("error at %0t: beat %0d sop %b eop %b wrong for pixel %0d",
				$time, beats_seen, sop, eop, pix_idx);
			beat_errors++;
		end
		if (data !== want_color) begin
			$display("error at %0t: beat %0d data %h, expected %h",
				$time, beats_seen, data, want_color);
			beat_errors++;
		end
		if (pix_idx == LAST_PIX) begin
			frames_done++;
			pix_idx = 0;
		end else begin
			pix_idx++;
		end
		// Solver count runs on across frames
		solver_idx = (solver_idx == NUM_SOLVERS - 1) ? 0 : solver_idx + 1;
		beats_seen++;
	endtask

	// ======================================================================
	// Sampling on the rising edge
	// ======================================================================
	always @(posedge iCLK) begin
		if (rst) begin
			pix_idx      = 0;
			solver_idx   = 0;
			beats_seen   = 0;
			frames_done  = 0;
			beat_errors  = 0;
			hold_errors  = 0;
			hex_errors   = 0;
			hold_pending = 1'b0;
			first_cycle  = 1'b1;
		end else begin
			if (first_cycle && valid !== 1'b0) begin
				$display("error at %0t: valid is %b right after reset, expected 0", $time, valid);
				beat_errors++;
			end
			first_cycle = 1'b0;
			check_digits();
			if (hold_pending)
				verify_hold();
			if (valid && ready)
				compare_beat();
			hold_pending = valid && !ready;
			held_sop     = sop;
			held_eop     = eop;
			held_data    = data;
			held_addr    = addr;
		end
	end

endmodule

//--- tests/tb_video_stream.sv
`timescale 1ns/1ns

module tb_video_stream import video_pkg::*; #(
	parameter string       TRACE_FILE = "tests/ready_trace.txt",
	parameter int unsigned SEED       = 32'h57cf_707f
);

	// Short frames for a quick run
	localparam int FRAME_W        = 8;
	localparam int FRAME_H        = 4;
	localparam int NUM_SOLVERS    = 3;
	localparam int FIFO_DEPTH     = 8;
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int TRACE_LEN      = 64;
	// Unused trace slots keep this value
	localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

	logic              iCLK;
	logic              rst;
	logic              ready;
	logic              valid;
	logic              sop;
	logic              eop;
	logic [7:0]        data;
	logic [ADDR_W-1:0] addr;
	logic [6:0]        hex0;
	logic [6:0]        hex1;
	logic [6:0]        hex2;
	logic [6:0]        hex3;

	// Trace contents and walk position
	logic [31:0] trace_mem [0:TRACE_LEN-1];
	int          pair_pos;
	logic [31:0] run_left;

	// Results from the monitor
	int frames_done;
	int beat_errors;
	int hold_errors;
	int hex_errors;
	int setup_errors;
	int timeout_errors;
	int assert_errors;
	int frames_wanted;

	// 10 ns clock
	initial iCLK = 1'b0;
	always #5 iCLK = ~iCLK;

	video_stream_top #(
		.FRAME_W     (FRAME_W),
		.FRAME_H     (FRAME_H),
		.NUM_SOLVERS (NUM_SOLVERS),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) i_video_stream_top (
		.iCLK  (iCLK),
		.rst   (rst),
		.ready (ready),
		.valid (valid),
		.sop   (sop),
		.eop   (eop),
		.data  (data),
		.addr  (addr),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2),
		.hex3  (hex3)
	);

	stream_monitor #(
		.FRAME_W     (FRAME_W),
		.FRAME_H     (FRAME_H),
		.NUM_SOLVERS (NUM_SOLVERS)
	) i_stream_monitor (
		.iCLK        (iCLK),
		.rst         (rst),
		.ready       (ready),
		.valid       (valid),
		.sop         (sop),
		.eop         (eop),
		.data        (data),
		.addr        (addr),
		.hex0        (hex0),
		.hex1        (hex1),
		.hex2        (hex2),
		.hex3        (hex3),
		.frames_done (frames_done),
		.beat_errors (beat_errors),
		.hold_errors (hold_errors),
		.hex_errors  (hex_errors)
	);

	// Protocol assertions on the top-level stream
	bind video_stream_top stream_checker i_stream_checker (
		.iCLK  (iCLK),
		.rst   (rst),
		.ready (ready),
		.valid (valid),
		.sop   (sop),
		.eop   (eop),
		.data  (data),
		.addr  (addr)
	);

	// ======================================================================
	// Ready pattern from the trace, then random
	// ======================================================================
	always @(posedge iCLK) begin
		if (rst) begin
			ready    <= 1'b0;
			pair_pos <= 1;
			run_left <= '0;
		end else if (run_left != 0) begin
			// Level holds for the rest of the run
			run_left <= run_left - 32'd1;
		end else if (pair_pos + 1 < TRACE_LEN && trace_mem[pair_pos] != END_MARK) begin
			ready    <= trace_mem[pair_pos][0];
			run_left <= (trace_mem[pair_pos + 1] == 0) ? '0 : trace_mem[pair_pos + 1] - 32'd1;
			pair_pos <= pair_pos + 2;
		end else begin
			ready <= 1'($urandom);
		end
	end

	// ======================================================================
	// Run control
	// ======================================================================
	initial begin
		int slot;
		int wait_cycles;
		rst            = 1'b1;
		ready          = 1'b0;
		setup_errors   = 0;
		timeout_errors = 0;
		assert_errors  = 0;
		void'($urandom(SEED));
		for (slot = 0; slot < TRACE_LEN; slot++)
			trace_mem[slot] = END_MARK;
		$readmemh(TRACE_FILE, trace_mem);
		// First entry is the frame count
		if (trace_mem[0] == END_MARK || trace_mem[0] == 0) begin
			$display("Trace file %s gave no frame count to run", TRACE_FILE);
			setup_errors  = 1;
			frames_wanted = 0;
		end else begin
			frames_wanted = int'(trace_mem[0]);
		end
		repeat (RESET_CYCLES) @(posedge iCLK);
		rst <= 1'b0;
		// Wait for the frames on the falling edge
		wait_cycles = 0;
		while (frames_done < frames_wanted && wait_cycles < TIMEOUT_CYCLES) begin
			@(negedge iCLK);
			wait_cycles++;
		end
		if (frames_done < frames_wanted) begin
			$display("Timeout: only %0d of %0d frames finished within %0d cycles",
				frames_done, frames_wanted, TIMEOUT_CYCLES);
			timeout_errors = 1;
		end
		// Let the digit check see the last frame
		repeat (4) @(posedge iCLK);
		@(negedge iCLK);
		assert_errors = i_video_stream_top.i_stream_checker.assert_errors;
		$write("Report: frames %0d of %0d, errors beat %0d hold %0d hex %0d",
			frames_done, frames_wanted, beat_errors, hold_errors, hex_errors);
		$display(" assert %0d setup %0d timeout %0d",
			assert_errors, setup_errors, timeout_errors);
		if (beat_errors + hold_errors + hex_errors + assert_errors + setup_errors +
			timeout_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- tests/ready_trace.txt
// First value alone: frames to run (hex)
// Then pairs per line: ready level, cycle count (hex)
12
// Free flow for about one frame
1 28
// Long stall, buffer fills and the scan stops
0 30
1 10
// Single-cycle toggling
0 1
1 1
0 2
1 1
0 3
1 2
// Stall across a frame boundary
0 40
1 20
0 8
1 5
0 1
1 18

//--- tb.f
design/video_pkg.sv
design/pixel_scan.sv
design/pixel_fifo.sv
design/video_stream_out.sv
design/hex_display.sv
design/video_stream_top.sv
tests/stream_checker.sv
tests/stream_monitor.sv
tests/tb_video_stream.sv

//--- Makefile
# Verilator flow for the video stream testbench

TOP       ?= tb_video_stream
TRACE     ?= tests/ready_trace.txt
# 32'h57cf_707f in decimal
SEED      ?= 1473212543
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing -Wno-fatal

PARAMS = -GTRACE_FILE='"$(TRACE)"' -GSEED=$(SEED)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		$(PARAMS) --Mdir $(OBJ_DIR)

# Failing status on an aborted run or on the fail message in the log
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
